/* include/output_config.svh */
`ifndef OUTPUT_CONFIG_SVH
`define OUTPUT_CONFIG_SVH

// cycles from an accepted begin_transmission to the register_result pulse
`define OUT_WAIT_REG_DELAY 4

// cycles from the fall of tx_busy to the next byte send pulse
`define OUT_INTER_BYTE_DELAY 20

// clock cycles spent on each digit of the multiplexed display
`define OUT_SCAN_DIVIDER 8

// largest value the seven low display digits can show
`define OUT_DISPLAY_MAX 9999999

`endif

/* source/output_pkg.sv */
`default_nettype none

package output_pkg;

    typedef logic [31:0] result_t;       // result word from the arithmetic unit
    typedef logic [5:0]  op_onehot_t;    // {dot, man, euc, avg, sum, read}
    typedef logic [7:0]  tx_byte_t;      // one byte for the UART transmitter
    typedef logic [31:0] bcd_digits_t;   // eight BCD digits, digit 7 in the top nibble
    typedef logic [3:0]  bcd_digit_t;
    typedef logic [6:0]  seg_t;          // {a, b, c, d, e, f, g}, a low bit lights the segment
    typedef logic [7:0]  anode_t;        // one enable per digit, active low

    // command pulses from the transfer FSM to the byte handler
    typedef struct packed {
        logic register_result;
        logic send_b0;
        logic send_b1;
        logic send_b2;
        logic send_b3;
    } byte_cmd_t;

endpackage

`default_nettype wire

/* source/bin_to_bcd.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd
    import output_pkg::*;
(
    input  wire           clk,
    input  wire           arst_n,
    input  wire           start,
    input  wire result_t  value,
    output logic          busy,
    output logic [27:0]   digits
);

    localparam int BIN_W = 24;  // the clamped value always fits
    localparam int DIG_N = 7;
    localparam int DIG_W = 4 * DIG_N;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_CONVERT,
        S_FINISH
    } state_t;

    state_t           state;
    logic [BIN_W-1:0] shift_q;
    logic [DIG_W-1:0] bcd_q;
    logic [DIG_W-1:0] bcd_adj;
    logic [4:0]       bit_cnt;

    // add 3 to every digit above 4 so the next shift carries into the digit above
    function automatic logic [DIG_W-1:0] add3(input logic [DIG_W-1:0] bcd);
        logic [DIG_W-1:0] res;
        res = bcd;
        for (int i = 0; i < DIG_N; i++) begin
            if (res[4*i +: 4] > 4'd4) begin
                res[4*i +: 4] = res[4*i +: 4] + 4'd3;
            end
        end
        return res;
    endfunction

    assign bcd_adj = add3(bcd_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                S_IDLE:    if (start) state <= S_LOAD;
                S_LOAD: begin
                    bit_cnt <= 5'(BIN_W - 1);
                    state   <= S_CONVERT;
                end
                S_CONVERT: begin
                    if (bit_cnt == '0) begin
                        state <= S_FINISH;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default:   state <= S_IDLE;     // finish returns to idle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            shift_q <= value[BIN_W-1:0];
        end
        if (state == S_LOAD) begin
            bcd_q <= '0;
        end
        if (state == S_CONVERT) begin
            bcd_q   <= {bcd_adj[DIG_W-2:0], shift_q[BIN_W-1]};  // msb first
            shift_q <= {shift_q[BIN_W-2:0], 1'b0};
        end
        if (state == S_FINISH) begin
            digits <= bcd_q;
        end
    end

    assign busy = (state != S_IDLE);

endmodule

`default_nettype wire

/* source/tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "output_config.svh"

module tx_ctrl
    import output_pkg::*;
#(
    parameter int WAIT_REG_DELAY   = `OUT_WAIT_REG_DELAY,
    parameter int INTER_BYTE_DELAY = `OUT_INTER_BYTE_DELAY
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              begin_transmission,
    input  wire              tx_busy,
    input  wire op_onehot_t  enables,
    output logic             tx_start,
    output logic             tx_sent,
    output byte_cmd_t        byte_cmd
);

    localparam int MAX_DELAY = (WAIT_REG_DELAY > INTER_BYTE_DELAY) ? WAIT_REG_DELAY
                                                                    : INTER_BYTE_DELAY;
    localparam int CNT_W     = $clog2(MAX_DELAY + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_REG,
        S_SEND,
        S_WAIT_BUSY_HI,
        S_WAIT_BUSY_LO,
        S_GAP,
        S_DONE
    } state_t;

    state_t           state;
    logic             read_mode;    // a read sends only the low byte
    logic [1:0]       byte_idx;
    logic [CNT_W-1:0] dly_cnt;
    logic             last_byte;

    assign last_byte = read_mode ? (byte_idx == 2'd0) : (byte_idx == 2'd3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            read_mode <= 1'b0;
            byte_idx  <= 2'd0;
            dly_cnt   <= '0;
            tx_start  <= 1'b0;
        end else begin
            tx_start <= (state == S_SEND);  // data is loaded by the send pulse
            case (state)
                S_IDLE: begin
                    if (begin_transmission) begin
                        read_mode <= enables[0];
                        byte_idx  <= 2'd0;
                        dly_cnt   <= CNT_W'(WAIT_REG_DELAY - 1);
                        state     <= S_WAIT_REG;
                    end
                end
                S_WAIT_REG: begin
                    if (dly_cnt == '0) begin
                        state <= S_SEND;    // register pulse goes out in this last cycle
                    end else begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end
                end
                S_SEND: begin
                    state <= S_WAIT_BUSY_HI;
                end
                S_WAIT_BUSY_HI: begin
                    if (tx_busy) begin
                        state <= S_WAIT_BUSY_LO;
                    end
                end
                S_WAIT_BUSY_LO: begin
                    if (!tx_busy) begin
                        if (last_byte) begin
                            state <= S_DONE;
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                            // the first gap cycle is the one after the fall
                            dly_cnt  <= CNT_W'(INTER_BYTE_DELAY - 2);
                            state    <= S_GAP;
                        end
                    end
                end
                S_GAP: begin
                    if (dly_cnt == '0) begin
                        state <= S_SEND;
                    end else begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        byte_cmd                 = '0;
        byte_cmd.register_result = (state == S_WAIT_REG) && (dly_cnt == '0);
        if (state == S_SEND) begin
            case (byte_idx)
                2'd0:    byte_cmd.send_b0 = 1'b1;
                2'd1:    byte_cmd.send_b1 = 1'b1;
                2'd2:    byte_cmd.send_b2 = 1'b1;
                default: byte_cmd.send_b3 = 1'b1;
            endcase
        end
    end

    assign tx_sent = (state == S_DONE);     // one cycle after the last byte finishes

    a_cmd_onehot0 : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(byte_cmd))
        else $error("tx_ctrl: more than one byte command active");

    a_no_start_when_busy : assert property (@(posedge clk) disable iff (!arst_n)
        !(tx_start && tx_busy))
        else $error("tx_ctrl: tx_start while transmitter busy");

endmodule

`default_nettype wire

/* source/byte_handler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "output_config.svh"

module byte_handler
    import output_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire byte_cmd_t   byte_cmd,
    input  wire op_onehot_t  enables,
    input  wire result_t     result_data,
    output logic             en_disp,
    output tx_byte_t         tx_data,
    output bcd_digits_t      bcd_out
);

    localparam result_t DISPLAY_MAX = `OUT_DISPLAY_MAX;

    result_t     result_q;
    op_onehot_t  enables_q;
    bcd_digit_t  op_digit;
    result_t     conv_value;
    logic        conv_busy;
    logic        conv_busy_q;
    logic [27:0] conv_digits;

    // operation number shown on the top digit, read is 1 and dot is 6
    function automatic bcd_digit_t op_to_digit(input op_onehot_t op);
        case (op)
            6'b000001: return 4'd1;
            6'b000010: return 4'd2;
            6'b000100: return 4'd3;
            6'b001000: return 4'd4;
            6'b010000: return 4'd5;
            6'b100000: return 4'd6;
            default:   return 4'd0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (byte_cmd.register_result) begin
            result_q  <= result_data;
            enables_q <= enables;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_data     <= '0;
            en_disp     <= 1'b0;
            conv_busy_q <= 1'b0;
        end else begin
            conv_busy_q <= conv_busy;
            if (byte_cmd.send_b0) begin
                tx_data <= result_q[7:0];
            end else if (byte_cmd.send_b1) begin
                tx_data <= result_q[15:8];
            end else if (byte_cmd.send_b2) begin
                tx_data <= result_q[23:16];
            end else if (byte_cmd.send_b3) begin
                tx_data <= result_q[31:24];
            end
            if (byte_cmd.register_result) begin
                en_disp <= 1'b0;                // blank until the new digits are ready
            end else if (conv_busy_q && !conv_busy) begin
                en_disp <= 1'b1;
            end
        end
    end

    assign conv_value = (result_data > DISPLAY_MAX) ? DISPLAY_MAX : result_data;
    assign op_digit   = op_to_digit(enables_q);
    assign bcd_out    = {op_digit, conv_digits};

    bin_to_bcd u_bin_to_bcd (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (byte_cmd.register_result),
        .value  (conv_value),
        .busy   (conv_busy),
        .digits (conv_digits)
    );

    a_enables_onehot : assert property (@(posedge clk) disable iff (!arst_n)
        byte_cmd.register_result |=> $onehot(enables_q))
        else $error("byte_handler: captured operation code is not one-hot");

endmodule

`default_nettype wire

/* source/seg7_driver.sv */
`timescale 1ns/1ps
`default_nettype none
`include "output_config.svh"

module seg7_driver
    import output_pkg::*;
#(
    parameter int SCAN_DIVIDER = `OUT_SCAN_DIVIDER
) (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               enable,
    input  wire bcd_digits_t  bcd_in,
    output seg_t              segments,
    output anode_t            an
);

    localparam int PRE_W = (SCAN_DIVIDER > 1) ? $clog2(SCAN_DIVIDER) : 1;

    logic [PRE_W-1:0] prescale;
    logic [2:0]       digit_idx;
    bcd_digit_t       nibble;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale  <= '0;
            digit_idx <= 3'd0;
        end else if (prescale == PRE_W'(SCAN_DIVIDER - 1)) begin
            prescale  <= '0;
            digit_idx <= digit_idx + 3'd1;  // wraps from digit 7 back to digit 0
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    assign nibble = bcd_in[4*digit_idx +: 4];
    assign an     = enable ? ~(anode_t'(1) << digit_idx) : '1;

    // segment order is {a, b, c, d, e, f, g}
    always_comb begin
        if (!enable) begin
            segments = 7'b1111111;
        end else begin
            case (nibble)
                4'd0:    segments = 7'b0000001;
                4'd1:    segments = 7'b1001111;
                4'd2:    segments = 7'b0010010;
                4'd3:    segments = 7'b0000110;
                4'd4:    segments = 7'b1001100;
                4'd5:    segments = 7'b0100100;
                4'd6:    segments = 7'b0100000;
                4'd7:    segments = 7'b0001111;
                4'd8:    segments = 7'b0000000;
                4'd9:    segments = 7'b0000100;
                default: segments = 7'b1111111;   // not a decimal digit, keep it dark
            endcase
        end
    end

    a_one_anode : assert property (@(posedge clk) disable iff (!arst_n)
        enable |-> $onehot(~an))
        else $error("seg7_driver: anode select is not one-cold while enabled");

endmodule

`default_nettype wire

/* source/output_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module output_interface
    import output_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              begin_transmission,
    input  wire              tx_busy,
    input  wire op_onehot_t  enables,
    input  wire result_t     result_data,
    output logic             tx_start,
    output logic             tx_sent,
    output tx_byte_t         tx_data,
    output seg_t             segments,
    output anode_t           an
);

    byte_cmd_t   byte_cmd;
    logic        en_disp;
    bcd_digits_t bcd_data;  // operation digit on top, result below

    tx_ctrl u_tx_ctrl (
        .clk                (clk),
        .arst_n             (arst_n),
        .begin_transmission (begin_transmission),
        .tx_busy            (tx_busy),
        .enables            (enables),
        .tx_start           (tx_start),
        .tx_sent            (tx_sent),
        .byte_cmd           (byte_cmd)
    );

    byte_handler u_byte_handler (
        .clk         (clk),
        .arst_n      (arst_n),
        .byte_cmd    (byte_cmd),
        .enables     (enables),
        .result_data (result_data),
        .en_disp     (en_disp),
        .tx_data     (tx_data),
        .bcd_out     (bcd_data)
    );

    seg7_driver u_seg7_driver (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (en_disp),
        .bcd_in   (bcd_data),
        .segments (segments),
        .an       (an)
    );

endmodule

`default_nettype wire

/* test/output_interface_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "output_config.svh"

module output_interface_tb
    import output_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int NUM_TRANSFERS = 24;  // four corner values, then random ones
    // longest transfer is four bytes with the slowest transmitter, plus the display scan
    localparam int WORST_CYCLES  = `OUT_WAIT_REG_DELAY + 4 * (6 + 40 + `OUT_INTER_BYTE_DELAY)
                                   + 60 + 16 * `OUT_SCAN_DIVIDER + 50;
    localparam int LIMIT_CYCLES  = 10 + NUM_TRANSFERS * WORST_CYCLES;

    logic       clk;
    logic       arst_n;
    logic       begin_transmission;
    logic       tx_busy;
    op_onehot_t enables;
    result_t    result_data;
    logic       tx_start;
    logic       tx_sent;
    tx_byte_t   tx_data;
    seg_t       segments;
    anode_t     an;

    integer     seed;
    int         errors;
    int         checks;
    int         sent_count;
    tx_byte_t   got_bytes[$];       // bytes seen at each tx_start of the current transfer

    output_interface dut0 (
        .clk                (clk),
        .arst_n             (arst_n),
        .begin_transmission (begin_transmission),
        .tx_busy            (tx_busy),
        .enables            (enables),
        .result_data        (result_data),
        .tx_start           (tx_start),
        .tx_sent            (tx_sent),
        .tx_data            (tx_data),
        .segments           (segments),
        .an                 (an)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int byte_count(input op_onehot_t op);
        return op[0] ? 1 : 4;   // read sends only the low byte
    endfunction

    // top digit is the operation number, the rest the clamped result in decimal
    function automatic bcd_digits_t expected_digits(input op_onehot_t op, input result_t value);
        bcd_digits_t d;
        result_t     v;
        v = (value > 32'd9999999) ? 32'd9999999 : value;
        d = '0;
        for (int i = 0; i < 7; i++) begin
            d[4*i +: 4] = 4'(v % 10);
            v = v / 10;
        end
        for (int i = 0; i < 6; i++) begin
            if (op[i]) d[31:28] = 4'(i + 1);
        end
        return d;
    endfunction

    // lit segments listed as {a..g} active high, then inverted for the board
    function automatic seg_t seg_pattern(input logic [3:0] digit);
        seg_t lit;
        case (digit)
            4'd0:    lit = 7'b1111110;
            4'd1:    lit = 7'b0110000;
            4'd2:    lit = 7'b1101101;
            4'd3:    lit = 7'b1111001;
            4'd4:    lit = 7'b0110011;
            4'd5:    lit = 7'b1011011;
            4'd6:    lit = 7'b1011111;
            4'd7:    lit = 7'b1110000;
            4'd8:    lit = 7'b1111111;
            4'd9:    lit = 7'b1111011;
            default: lit = 7'b0000000;
        endcase
        return ~lit;
    endfunction

    function automatic result_t corner_value(input int i);
        case (i)
            0:       return 32'd0;
            1:       return 32'd9999999;
            2:       return 32'd10000000;
            default: return 32'hffffffff;
        endcase
    endfunction

    // transmitter model, busy after 1 to 3 cycles and held for 2 to 40
    initial begin : tx_model
        int lag;
        int hold;
        forever begin
            @(negedge clk);
            if (arst_n && tx_start) begin
                lag  = 1 + {$random(seed)} % 3;
                hold = 2 + {$random(seed)} % 39;
                repeat (lag) @(posedge clk);
                #1 tx_busy = 1'b1;
                repeat (hold) @(posedge clk);
                #1 tx_busy = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (tx_start) begin
                got_bytes.push_back(tx_data);
                checks++;
                if (tx_busy) begin
                    errors++;
                    $display("tx_start went high while the transmitter was still busy");
                end
            end
            if (tx_sent) sent_count++;
        end
    end

    task automatic pulse_begin();
        begin_transmission = 1'b1;
        @(posedge clk);
        #1 begin_transmission = 1'b0;
    endtask

    task automatic check_display(input bcd_digits_t exp_digits);
        int     waited;
        int     idx;
        anode_t seen;
        seg_t   exp_seg;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (an == 8'hff && waited < 60);     // conversion needs 27 cycles
        if (an == 8'hff) begin
            errors++;
            $display("display stayed blank after the transfer finished");
            return;
        end
        seen = '0;
        repeat (16 * `OUT_SCAN_DIVIDER) begin
            checks++;
            if (!$onehot(~an)) begin
                errors++;
                $display("anode select does not have exactly one digit on: %h", an);
            end else begin
                idx = 0;
                for (int k = 0; k < 8; k++) begin
                    if (!an[k]) idx = k;
                end
                seen[idx] = 1'b1;
                exp_seg   = seg_pattern(exp_digits[4*idx +: 4]);
                if (segments !== exp_seg) begin
                    errors++;
                    $display("mismatch segments digit %0d: got %h expected %h",
                             idx, segments, exp_seg);
                end
            end
            @(negedge clk);
        end
        if (seen != 8'hff) begin
            errors++;
            $display("not every display digit was scanned, seen mask %h", seen);
        end
    endtask

    task automatic run_transfer(input op_onehot_t op, input result_t value, input bit extra);
        int       n_exp;
        tx_byte_t exp_byte;
        @(posedge clk);
        #1;
        got_bytes.delete();
        sent_count  = 0;
        enables     = op;
        result_data = value;
        pulse_begin();
        if (extra) begin
            @(posedge clk);
            #1 pulse_begin();           // lands while waiting for the register pulse
            repeat (3) @(posedge clk);
            #1 pulse_begin();           // lands while the first byte is in flight
        end
        do @(negedge clk); while (!tx_sent);
        check_display(expected_digits(op, value));
        n_exp = byte_count(op);
        checks++;
        if (got_bytes.size() != n_exp) begin
            errors++;
            $display("transfer sent %0d bytes instead of %0d", got_bytes.size(), n_exp);
        end
        for (int i = 0; i < n_exp && i < got_bytes.size(); i++) begin
            exp_byte = value[8*i +: 8];
            if (got_bytes[i] !== exp_byte) begin
                errors++;
                $display("mismatch tx_data byte %0d: got %h expected %h",
                         i, got_bytes[i], exp_byte);
            end
        end
        checks++;
        if (sent_count != 1) begin
            errors++;
            $display("saw %0d tx_sent pulses in one transfer instead of one", sent_count);
        end
    endtask

    initial begin : stimulus
        result_t    value;
        op_onehot_t op;
        seed               = 32'h20f5_b343;
        errors             = 0;
        checks             = 0;
        sent_count         = 0;
        arst_n             = 1'b0;
        begin_transmission = 1'b0;
        tx_busy            = 1'b0;
        enables            = 6'b000001;
        result_data        = '0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (2) @(negedge clk);
        checks++;
        if (tx_start !== 1'b0) begin
            errors++;
            $display("mismatch tx_start after reset: got %h expected %h", tx_start, 1'b0);
        end
        if (tx_sent !== 1'b0) begin
            errors++;
            $display("mismatch tx_sent after reset: got %h expected %h", tx_sent, 1'b0);
        end
        if (tx_data !== 8'h00) begin
            errors++;
            $display("mismatch tx_data after reset: got %h expected %h", tx_data, 8'h00);
        end
        if (an !== 8'hff) begin
            errors++;
            $display("mismatch an after reset: got %h expected %h", an, 8'hff);
        end
        for (int t = 0; t < NUM_TRANSFERS; t++) begin
            if (t < 4) begin
                value = corner_value(t);
                op    = op_onehot_t'(1) << t;
            end else begin
                value = $random(seed);
                op    = op_onehot_t'(1) << ({$random(seed)} % 6);
            end
            run_transfer(op, value, (t % 3) == 1);
        end
        $display("transfers %0d, checks %0d, errors %0d", NUM_TRANSFERS, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(CLK_PERIOD * LIMIT_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* output_interface.f */
+incdir+include
source/output_pkg.sv
source/bin_to_bcd.sv
source/tx_ctrl.sv
source/byte_handler.sv
source/seg7_driver.sv
source/output_interface.sv
test/output_interface_tb.sv
